// File: flist.f
+incdir+logic
logic/eth_pkg.sv
logic/ip_pkg.sv
logic/ip_hdr_checksum.sv
logic/ip_frame_sequencer.sv
logic/axis_skid_buffer.sv
logic/ip_eth_tx.sv
tests/ip_eth_tx_properties.sv
tests/ip_eth_tx_tb.sv

// File: logic/axis_skid_buffer.sv
`timescale 1ns/10ps

module axis_skid_buffer (
    input  logic               clk,
    input  logic               reset,
    input  eth_pkg::eth_beat_t in_beat,
    input  logic               in_valid,
    output logic               in_accept,
    output eth_pkg::eth_beat_t m_pay,
    output logic               m_pay_valid,
    input  logic               m_pay_ready
);

    import eth_pkg::*;

    eth_beat_t spare_beat;
    logic      spare_valid;
    logic      accept_next;
    logic      out_valid_next;
    logic      spare_valid_next;
    logic      load_out_from_in;
    logic      load_out_from_spare;
    logic      load_spare;

    // Room next cycle if the sink drains or nothing is held
    assign accept_next = m_pay_ready || (!spare_valid && !m_pay_valid);

    always_comb begin
        out_valid_next      = m_pay_valid;
        spare_valid_next    = spare_valid;
        load_out_from_in    = 1'b0;
        load_out_from_spare = 1'b0;
        load_spare          = 1'b0;
        if (in_accept) begin
            if (m_pay_ready || !m_pay_valid) begin
                out_valid_next   = in_valid;
                load_out_from_in = 1'b1;
            end else begin
                // Output stalled, park the beat
                spare_valid_next = in_valid;
                load_spare       = 1'b1;
            end
        end else if (m_pay_ready) begin
            out_valid_next      = spare_valid;
            spare_valid_next    = 1'b0;
            load_out_from_spare = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            m_pay_valid <= 1'b0;
            spare_valid <= 1'b0;
            in_accept   <= 1'b0;
        end else begin
            m_pay_valid <= out_valid_next;
            spare_valid <= spare_valid_next;
            in_accept   <= accept_next;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out_from_in) begin
            m_pay <= in_beat;
        end else if (load_out_from_spare) begin
            m_pay <= spare_beat;
        end
        if (load_spare) begin
            spare_beat <= in_beat;
        end
    end

endmodule

// File: logic/eth_pkg.sv
package eth_pkg;

    // MAC header passed to the Ethernet side in parallel
    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    // One byte of a payload stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        // Bad frame, set on the final byte only
        logic       user;
    } eth_beat_t;

endpackage

// File: logic/ip_consts.svh
`ifndef IP_CONSTS_SVH
`define IP_CONSTS_SVH

// IPv4 header without options
`define IP_HDR_BYTES 20

// Header seen as 16-bit words for the checksum
`define IP_HDR_WORDS 10

// Fixed version and header length in 32-bit words
`define IP_VERSION 4
`define IP_IHL 5

// Width of one stream byte
`define IP_BYTE_W 8

`endif

// File: logic/ip_eth_tx.sv
`timescale 1ns/10ps

module ip_eth_tx (
    input  logic                clk,
    input  logic                reset,

    // IP header and payload from the sender
    input  ip_pkg::ip_hdr_req_t s_hdr,
    input  logic                s_hdr_valid,
    output logic                s_hdr_ready,
    input  eth_pkg::eth_beat_t  s_pay,
    input  logic                s_pay_valid,
    output logic                s_pay_ready,

    // Ethernet header and payload toward the MAC
    output eth_pkg::eth_hdr_t   m_eth_hdr,
    output logic                m_eth_hdr_valid,
    input  logic                m_eth_hdr_ready,
    output eth_pkg::eth_beat_t  m_pay,
    output logic                m_pay_valid,
    input  logic                m_pay_ready,

    output logic                busy,
    output logic                err_len_mismatch
);

    import ip_pkg::*;
    import eth_pkg::*;

    logic        csum_start;
    ip_hdr_u     csum_hdr;
    logic [15:0] csum_sum;
    logic        csum_done;
    eth_beat_t   out_beat;
    logic        out_valid;
    logic        out_accept;

    ip_frame_sequencer u_sequencer (
        .clk              (clk),
        .reset            (reset),
        .s_hdr            (s_hdr),
        .s_hdr_valid      (s_hdr_valid),
        .s_hdr_ready      (s_hdr_ready),
        .s_pay            (s_pay),
        .s_pay_valid      (s_pay_valid),
        .s_pay_ready      (s_pay_ready),
        .m_eth_hdr        (m_eth_hdr),
        .m_eth_hdr_valid  (m_eth_hdr_valid),
        .m_eth_hdr_ready  (m_eth_hdr_ready),
        .csum_start       (csum_start),
        .csum_hdr         (csum_hdr),
        .csum             (csum_sum),
        .csum_done        (csum_done),
        .out_beat         (out_beat),
        .out_valid        (out_valid),
        .out_accept       (out_accept),
        .busy             (busy),
        .err_len_mismatch (err_len_mismatch)
    );

    ip_hdr_checksum u_checksum (
        .clk   (clk),
        .reset (reset),
        .start (csum_start),
        .hdr   (csum_hdr),
        .sum   (csum_sum),
        .done  (csum_done)
    );

    axis_skid_buffer u_skid (
        .clk         (clk),
        .reset       (reset),
        .in_beat     (out_beat),
        .in_valid    (out_valid),
        .in_accept   (out_accept),
        .m_pay       (m_pay),
        .m_pay_valid (m_pay_valid),
        .m_pay_ready (m_pay_ready)
    );

endmodule

// File: logic/ip_frame_sequencer.sv
`timescale 1ns/10ps
`include "ip_consts.svh"

module ip_frame_sequencer (
    input  logic                clk,
    input  logic                reset,

    input  ip_pkg::ip_hdr_req_t s_hdr,
    input  logic                s_hdr_valid,
    output logic                s_hdr_ready,

    input  eth_pkg::eth_beat_t  s_pay,
    input  logic                s_pay_valid,
    output logic                s_pay_ready,

    output eth_pkg::eth_hdr_t   m_eth_hdr,
    output logic                m_eth_hdr_valid,
    input  logic                m_eth_hdr_ready,

    output logic                csum_start,
    output ip_pkg::ip_hdr_u     csum_hdr,
    input  logic [15:0]         csum,
    input  logic                csum_done,

    output eth_pkg::eth_beat_t  out_beat,
    output logic                out_valid,
    input  logic                out_accept,

    output logic                busy,
    output logic                err_len_mismatch
);

    import ip_pkg::*;

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_HEADER  = 2'd1;
    localparam logic [1:0] ST_PAYLOAD = 2'd2;

    // Header word holding the checksum
    localparam logic [3:0] CSUM_WORD     = 4'd5;
    localparam logic [4:0] LAST_HDR_BYTE = 5'(`IP_HDR_BYTES - 1);

    logic [1:0]            state;
    logic [1:0]            state_next;
    logic [4:0]            hdr_ptr;
    logic [15:0]           byte_count;
    ip_hdr_u               hdr_in;
    ip_hdr_u               hdr_r;
    logic                  hdr_xfer;
    logic                  pay_xfer;
    logic                  hdr_step;
    logic                  len_bad;
    logic                  eth_hdr_valid_next;
    logic [15:0]           cur_word;
    logic [`IP_BYTE_W-1:0] cur_byte;

    // Request to wire layout with the checksum left zero for the summer
    always_comb begin
        hdr_in.fields.version   = 4'(`IP_VERSION);
        hdr_in.fields.ihl       = 4'(`IP_IHL);
        hdr_in.fields.dscp      = s_hdr.dscp;
        hdr_in.fields.ecn       = s_hdr.ecn;
        hdr_in.fields.total_len = s_hdr.total_len;
        hdr_in.fields.iden      = s_hdr.iden;
        hdr_in.fields.flags     = s_hdr.flags;
        hdr_in.fields.frag_off  = s_hdr.frag_off;
        hdr_in.fields.ttl       = s_hdr.ttl;
        hdr_in.fields.protocol  = s_hdr.protocol;
        hdr_in.fields.checksum  = '0;
        hdr_in.fields.src_ip    = s_hdr.src_ip;
        hdr_in.fields.dest_ip   = s_hdr.dest_ip;
    end

    assign hdr_xfer    = s_hdr_valid && s_hdr_ready;
    assign s_pay_ready = (state == ST_PAYLOAD) && out_accept;
    assign pay_xfer    = s_pay_valid && s_pay_ready;
    assign len_bad     = byte_count != 16'd1;
    assign busy        = state != ST_IDLE;
    assign csum_hdr    = hdr_r;
    assign csum_start  = hdr_xfer;

    assign eth_hdr_valid_next = (m_eth_hdr_valid && !m_eth_hdr_ready) || hdr_xfer;

    // Serializer with the checksum swapped in for its word
    assign cur_word = (hdr_ptr[4:1] == CSUM_WORD) ? csum : hdr_r.words[hdr_ptr[4:1]];
    assign cur_byte = hdr_ptr[0] ? cur_word[`IP_BYTE_W-1:0]
                                 : cur_word[2*`IP_BYTE_W-1:`IP_BYTE_W];

    // Stall on the checksum bytes until the sum is in
    assign hdr_step = (state == ST_HEADER) && out_accept &&
                      ((hdr_ptr[4:1] != CSUM_WORD) || csum_done);

    always_comb begin
        out_valid = 1'b0;
        out_beat  = '0;
        if (state == ST_HEADER) begin
            out_valid     = hdr_step;
            out_beat.data = cur_byte;
        end else if (state == ST_PAYLOAD) begin
            out_valid     = pay_xfer;
            out_beat.data = s_pay.data;
            out_beat.last = s_pay.last;
            // Count off by either side marks the frame bad
            out_beat.user = s_pay.user || (s_pay.last && len_bad);
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (hdr_xfer) begin
                    state_next = ST_HEADER;
                end
            end
            ST_HEADER: begin
                if (hdr_step && hdr_ptr == LAST_HDR_BYTE) begin
                    state_next = ST_PAYLOAD;
                end
            end
            ST_PAYLOAD: begin
                if (pay_xfer && s_pay.last) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state            <= ST_IDLE;
            s_hdr_ready      <= 1'b0;
            m_eth_hdr_valid  <= 1'b0;
            err_len_mismatch <= 1'b0;
            hdr_ptr          <= '0;
            byte_count       <= '0;
        end else begin
            state            <= state_next;
            m_eth_hdr_valid  <= eth_hdr_valid_next;
            s_hdr_ready      <= (state_next == ST_IDLE) && !eth_hdr_valid_next;
            err_len_mismatch <= pay_xfer && s_pay.last && len_bad;
            if (hdr_xfer) begin
                hdr_ptr    <= '0;
                byte_count <= s_hdr.total_len - 16'(`IP_HDR_BYTES);
            end else begin
                if (hdr_step && hdr_ptr != LAST_HDR_BYTE) begin
                    hdr_ptr <= hdr_ptr + 5'd1;
                end
                // Held at zero so an over-long payload stays flagged
                if (pay_xfer && byte_count != 16'd0) begin
                    byte_count <= byte_count - 16'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_xfer) begin
            hdr_r     <= hdr_in;
            m_eth_hdr <= s_hdr.eth;
        end
    end

endmodule

// File: logic/ip_hdr_checksum.sv
`timescale 1ns/10ps
`include "ip_consts.svh"

module ip_hdr_checksum (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  ip_pkg::ip_hdr_u hdr,
    output logic [15:0]     sum,
    output logic            done
);

    localparam logic [3:0] LAST_WORD = 4'(`IP_HDR_WORDS - 1);

    logic [15:0] acc;
    logic [16:0] acc_add;
    logic [3:0]  word_idx;
    logic        running;

    // Plain add, carry folded back in on the next line
    assign acc_add = {1'b0, acc} + {1'b0, hdr.words[word_idx]};

    // Valid whenever done is high
    assign sum = ~acc;

    always_ff @(posedge clk) begin
        if (reset) begin
            running  <= 1'b0;
            done     <= 1'b0;
            word_idx <= '0;
        end else if (start) begin
            running  <= 1'b1;
            done     <= 1'b0;
            word_idx <= '0;
        end else if (running) begin
            if (word_idx == LAST_WORD) begin
                running <= 1'b0;
                done    <= 1'b1;
            end else begin
                word_idx <= word_idx + 4'd1;
            end
        end
    end

    // One word per cycle with end-around carry
    always_ff @(posedge clk) begin
        if (start) begin
            acc <= '0;
        end else if (running) begin
            acc <= acc_add[15:0] + 16'(acc_add[16]);
        end
    end

endmodule

// File: logic/ip_pkg.sv
`include "ip_consts.svh"

package ip_pkg;

    // IPv4 header fields, first byte on the wire at the top
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] total_len;
        logic [15:0] iden;
        logic [2:0]  flags;
        logic [12:0] frag_off;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] checksum;
        logic [31:0] src_ip;
        logic [31:0] dest_ip;
    } ip_fields_t;

    // Same header as fields or as words, word 0 sent first
    typedef union packed {
        ip_fields_t                          fields;
        logic [0:`IP_HDR_WORDS-1][15:0]      words;
    } ip_hdr_u;

    // What the sender supplies with each frame
    typedef struct packed {
        eth_pkg::eth_hdr_t eth;
        logic [5:0]        dscp;
        logic [1:0]        ecn;
        logic [15:0]       total_len;
        logic [15:0]       iden;
        logic [2:0]        flags;
        logic [12:0]       frag_off;
        logic [7:0]        ttl;
        logic [7:0]        protocol;
        logic [31:0]       src_ip;
        logic [31:0]       dest_ip;
    } ip_hdr_req_t;

endpackage

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module ip_eth_tx_tb \
    && ./obj_dir/Vip_eth_tx_tb | tee /dev/stderr | grep -q "Simulation completed successfully" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: tests/ip_eth_tx_properties.sv
`timescale 1ns/10ps

module ip_eth_tx_properties (
    input logic               clk,
    input logic               reset,
    input logic               s_hdr_ready,
    input logic               s_pay_ready,
    input eth_pkg::eth_hdr_t  m_eth_hdr,
    input logic               m_eth_hdr_valid,
    input logic               m_eth_hdr_ready,
    input eth_pkg::eth_beat_t m_pay,
    input logic               m_pay_valid,
    input logic               m_pay_ready,
    input logic               busy,
    input logic               err_len_mismatch
);

    // A stalled payload beat stays put
    pay_hold: assert property (@(posedge clk) disable iff (reset)
        (m_pay_valid && !m_pay_ready) |=> (m_pay_valid && $stable(m_pay)))
        else $error("m_pay changed or dropped while stalled");

    // Ethernet header waits for its ready
    eth_hdr_hold: assert property (@(posedge clk) disable iff (reset)
        (m_eth_hdr_valid && !m_eth_hdr_ready) |=> (m_eth_hdr_valid && $stable(m_eth_hdr)))
        else $error("m_eth_hdr changed or dropped while stalled");

    // Everything quiet right after reset
    reset_quiet: assert property (@(posedge clk)
        reset |=> (!s_hdr_ready && !s_pay_ready && !m_eth_hdr_valid &&
                   !m_pay_valid && !busy && !err_len_mismatch))
        else $error("control output high after reset");

endmodule

bind ip_eth_tx ip_eth_tx_properties u_props (.*);

// File: tests/ip_eth_tx_tb.sv
`timescale 1ns/10ps
`include "ip_consts.svh"

module ip_eth_tx_tb;

    import eth_pkg::*;
    import ip_pkg::*;

    // Total bytes over all tests for sizing the watchdog
    localparam int TEST_BYTES  = 210;
    localparam int WATCHDOG_NS = 40 * TEST_BYTES * 4 + 8000;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    ip_hdr_req_t s_hdr = '0;
    logic        s_hdr_valid = 1'b0;
    logic        s_hdr_ready;
    eth_beat_t   s_pay = '0;
    logic        s_pay_valid = 1'b0;
    logic        s_pay_ready;
    eth_hdr_t    m_eth_hdr;
    logic        m_eth_hdr_valid;
    logic        m_eth_hdr_ready = 1'b0;
    eth_beat_t   m_pay;
    logic        m_pay_valid;
    logic        m_pay_ready = 1'b0;
    logic        busy;
    logic        err_len_mismatch;

    logic [31:0] rng_data = 32'h59b47885;
    logic [31:0] rng_bp = 32'h59b47885 ^ 32'h0000ffff;
    logic        bp_on = 1'b0;
    logic        eth_hold = 1'b0;
    int          errors = 0;
    int          tests_run = 0;
    int          err_pulses = 0;

    eth_beat_t exp_q[$];
    eth_beat_t rx_q[$];
    eth_beat_t pay_q[$];
    eth_hdr_t  exp_eth_q[$];
    eth_hdr_t  rx_eth_q[$];

    ip_eth_tx uut (.*);

    initial begin
        forever begin
            #20 clk = ~clk;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Run timed out before all tests finished");
        $display("Simulation failed");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_data = xorshift(rng_data);
        return rng_data;
    endfunction

    // Ready levels change first, then the coming transfer is recorded
    always @(negedge clk) begin
        rng_bp = xorshift(rng_bp);
        m_pay_ready = bp_on ? (rng_bp[1:0] != 2'b00) : 1'b1;
        m_eth_hdr_ready = !eth_hold;
        if (!reset) begin
            if (m_pay_valid && m_pay_ready) begin
                rx_q.push_back(m_pay);
            end
            if (m_eth_hdr_valid && m_eth_hdr_ready) begin
                rx_eth_q.push_back(m_eth_hdr);
            end
            if (err_len_mismatch) begin
                err_pulses++;
            end
        end
    end

    task automatic check_beat(input string name, input eth_beat_t got, input eth_beat_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got data=%h last=%h user=%h expected data=%h last=%h user=%h",
                     name, got.data, got.last, got.user, exp.data, exp.last, exp.user);
            errors++;
        end
    endtask

    task automatic check_eth_hdr(input string name, input eth_hdr_t got, input eth_hdr_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic ip_hdr_req_t make_req(input int pay_len);
        ip_hdr_req_t r;
        r.eth.dest_mac = 48'({next_rand(), next_rand()});
        r.eth.src_mac  = 48'({next_rand(), next_rand()});
        r.eth.eth_type = 16'h0800;
        {r.dscp, r.ecn, r.iden} = 24'(next_rand());
        {r.flags, r.frag_off} = 16'(next_rand());
        r.ttl       = 8'(next_rand());
        r.protocol  = 8'(next_rand());
        r.src_ip    = next_rand();
        r.dest_ip   = next_rand();
        r.total_len = 16'(pay_len + `IP_HDR_BYTES);
        return r;
    endfunction

    // Expected wire bytes of the header, then random payload of n_sent bytes
    task automatic plan_frame(input ip_hdr_req_t r, input int n_sent);
        logic [7:0]  b[`IP_HDR_BYTES];
        logic [31:0] acc;
        eth_beat_t   beat;
        int          counted;
        b[0] = {4'(`IP_VERSION), 4'(`IP_IHL)};
        b[1] = {r.dscp, r.ecn};
        {b[2], b[3]} = r.total_len;
        {b[4], b[5]} = r.iden;
        {b[6], b[7]} = {r.flags, r.frag_off};
        b[8] = r.ttl;
        b[9] = r.protocol;
        {b[10], b[11]} = 16'h0000;
        {b[12], b[13], b[14], b[15]} = r.src_ip;
        {b[16], b[17], b[18], b[19]} = r.dest_ip;
        acc = 0;
        for (int w = 0; w < `IP_HDR_WORDS; w++) begin
            acc = acc + {16'h0, b[2*w], b[2*w+1]};
        end
        while (acc[31:16] != 0) begin
            acc = {16'h0, acc[15:0]} + {16'h0, acc[31:16]};
        end
        {b[10], b[11]} = ~acc[15:0];
        for (int i = 0; i < `IP_HDR_BYTES; i++) begin
            beat.data = b[i];
            beat.last = 1'b0;
            beat.user = 1'b0;
            exp_q.push_back(beat);
        end
        counted = int'(r.total_len) - `IP_HDR_BYTES;
        for (int i = 0; i < n_sent; i++) begin
            beat.data = 8'(next_rand());
            beat.last = (i == n_sent - 1);
            beat.user = 1'b0;
            pay_q.push_back(beat);
            // Flagged on the final byte when the count is off
            beat.user = beat.last && (n_sent != counted);
            exp_q.push_back(beat);
        end
        exp_eth_q.push_back(r.eth);
    endtask

    task automatic send_header(input ip_hdr_req_t r);
        @(negedge clk);
        s_hdr = r;
        s_hdr_valid = 1'b1;
        while (!s_hdr_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        s_hdr_valid = 1'b0;
    endtask

    task automatic send_payload(input bit gaps);
        while (pay_q.size() > 0) begin
            @(negedge clk);
            if (gaps && (next_rand() & 32'h3) == 0) begin
                s_pay_valid = 1'b0;
            end else begin
                s_pay_valid = 1'b1;
                s_pay = pay_q[0];
            end
            if (s_pay_valid && s_pay_ready) begin
                void'(pay_q.pop_front());
            end
        end
        @(negedge clk);
        s_pay_valid = 1'b0;
    endtask

    // Waits for every expected beat and header, then compares in order
    task automatic compare_streams();
        int waited;
        waited = 0;
        while ((rx_q.size() < exp_q.size() || rx_eth_q.size() < exp_eth_q.size())
               && waited < 400) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= 400) begin
            $display("Output stream stopped before all expected bytes arrived");
            errors++;
        end
        repeat (4) @(negedge clk);
        if (rx_q.size() != exp_q.size() || rx_eth_q.size() != exp_eth_q.size()) begin
            $display("Received %0d bytes and %0d headers, expected %0d and %0d",
                     rx_q.size(), rx_eth_q.size(), exp_q.size(), exp_eth_q.size());
            errors++;
        end
        while (rx_q.size() > 0 && exp_q.size() > 0) begin
            check_beat("m_pay", rx_q.pop_front(), exp_q.pop_front());
        end
        while (rx_eth_q.size() > 0 && exp_eth_q.size() > 0) begin
            check_eth_hdr("m_eth_hdr", rx_eth_q.pop_front(), exp_eth_q.pop_front());
        end
        rx_q.delete();
        exp_q.delete();
        rx_eth_q.delete();
        exp_eth_q.delete();
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests_run++;
        $display("Test %0d %s: %0d errors", tests_run, name, errors - start_errors);
    endtask

    task automatic reset_state_test();
        int e0;
        int waited;
        e0 = errors;
        check_flag("m_pay_valid", m_pay_valid, 1'b0);
        check_flag("m_eth_hdr_valid", m_eth_hdr_valid, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_flag("err_len_mismatch", err_len_mismatch, 1'b0);
        check_flag("s_hdr_ready", s_hdr_ready, 1'b0);
        check_flag("s_pay_ready", s_pay_ready, 1'b0);
        waited = 0;
        while (!s_hdr_ready && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        if (!s_hdr_ready) begin
            $display("s_hdr_ready never rose after reset");
            errors++;
        end
        report_test("reset state", e0);
    endtask

    task automatic frame_test(input string name, input int pay_len, input int n_sent,
                              input bit stress, input int exp_pulses);
        ip_hdr_req_t r;
        int          e0;
        int          p0;
        e0 = errors;
        p0 = err_pulses;
        r = make_req(pay_len);
        plan_frame(r, n_sent);
        bp_on = stress;
        send_header(r);
        check_flag("busy", busy, 1'b1);
        send_payload(stress);
        compare_streams();
        bp_on = 1'b0;
        check_flag("busy", busy, 1'b0);
        check_flag("err_len_mismatch pulses", (err_pulses - p0) == exp_pulses, 1'b1);
        report_test(name, e0);
    endtask

    task automatic held_header_test();
        ip_hdr_req_t r1;
        ip_hdr_req_t r2;
        int          e0;
        e0 = errors;
        r1 = make_req(10);
        r2 = make_req(6);
        plan_frame(r1, 10);
        eth_hold = 1'b1;
        send_header(r1);
        send_payload(1'b0);
        @(negedge clk);
        s_hdr = r2;
        s_hdr_valid = 1'b1;
        repeat (8) begin
            @(negedge clk);
            check_flag("s_hdr_ready", s_hdr_ready, 1'b0);
            check_flag("m_eth_hdr_valid", m_eth_hdr_valid, 1'b1);
        end
        plan_frame(r2, 6);
        eth_hold = 1'b0;
        send_header(r2);
        send_payload(1'b0);
        compare_streams();
        report_test("back-to-back with held header", e0);
    endtask

    initial begin
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        reset_state_test();
        frame_test("matching length", 24, 24, 1'b0, 0);
        frame_test("back-pressure and gaps", 24, 24, 1'b1, 0);
        frame_test("short payload", 30, 12, 1'b0, 1);
        frame_test("long payload", 8, 14, 1'b0, 1);
        held_header_test();
        $display("Tests run: %0d, checks failed: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
